/* hw/axi_wr_pkg.sv */
package axi_wr_pkg;

  // AXI4 write channel widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int ID_WIDTH = 4;
  localparam int LEN_WIDTH = 8;

  // Burst type and response codes
  localparam logic [1:0] BURST_INCR = 2'b01;
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // AXI beats that make up one memory chunk
  localparam int BEATS_PER_CHUNK = 4;

endpackage

/* hw/sdram_cmd_pkg.sv */
package sdram_cmd_pkg;

  // Address step of one memory write command
  localparam int CHUNK_BYTES = 16;

  // Buffer depths
  localparam int CMD_FIFO_DEPTH = 16;
  localparam int DATA_FIFO_DEPTH = 512;
  localparam int ID_FIFO_DEPTH = 8;

  // Command word is address, ID and seq flag
  localparam int CMD_WIDTH = axi_wr_pkg::ADDR_WIDTH + axi_wr_pkg::ID_WIDTH + 1;

endpackage

/* hw/write_capture_fsm.sv */
`timescale 1ns/1ps

module write_capture_fsm (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              axi_awvalid_i,
  input  logic [axi_wr_pkg::ADDR_WIDTH-1:0] axi_awaddr_i,
  input  logic [axi_wr_pkg::LEN_WIDTH-1:0]  axi_awlen_i,
  input  logic [1:0]                        axi_awburst_i,
  input  logic [axi_wr_pkg::ID_WIDTH-1:0]   axi_awid_i,
  input  logic                              axi_wvalid_i,
  input  logic [axi_wr_pkg::DATA_WIDTH-1:0] axi_wdata_i,
  input  logic [axi_wr_pkg::STRB_WIDTH-1:0] axi_wstrb_i,
  input  logic                              axi_wlast_i,
  input  logic                              burst_ready_i,
  input  logic                              id_ready_i,
  input  logic                              data_ready_i,
  output logic                              axi_awready_o,
  output logic                              axi_wready_o,
  output logic                              burst_valid_o,
  output logic                              wr_valid_o
);
  import axi_wr_pkg::*;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_FILL = 2'd1;
  localparam logic [1:0] ST_BUSY = 2'd2;

  logic [1:0] state;
  logic       aw_en;
  logic       w_en;

  // Address is only taken when both the chunker and the ID FIFO can take it
  assign axi_awready_o = aw_en & burst_ready_i & id_ready_i;
  assign axi_wready_o = w_en & data_ready_i;
  assign burst_valid_o = axi_awvalid_i & axi_awready_o;
  assign wr_valid_o = axi_wvalid_i & axi_wready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_IDLE;
      aw_en <= 1'b0;
      w_en <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (burst_valid_o) begin
            state <= ST_FILL;
            aw_en <= 1'b0;
            w_en <= 1'b1;
          end else begin
            aw_en <= 1'b1;
          end
        end
        ST_FILL: begin
          if (wr_valid_o && axi_wlast_i) begin
            w_en <= 1'b0;
            if (burst_ready_i && data_ready_i) begin
              state <= ST_IDLE;
              aw_en <= 1'b1;
            end else begin
              state <= ST_BUSY;
            end
          end
        end
        ST_BUSY: begin
          // Wait for the chunker to drain and for room in the data FIFO
          if (burst_ready_i && data_ready_i) begin
            state <= ST_IDLE;
            aw_en <= 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
          aw_en <= 1'b0;
          w_en <= 1'b0;
        end
      endcase
    end
  end

  a_burst_incr: assert property (@(posedge clock) disable iff (reset)
    burst_valid_o |-> axi_awburst_i == BURST_INCR)
    else $error("Only INCR write bursts are supported");

  a_burst_len: assert property (@(posedge clock) disable iff (reset)
    burst_valid_o |-> axi_awlen_i[1:0] == 2'b11)
    else $error("Burst length is not a multiple of four beats");

  a_burst_align: assert property (@(posedge clock) disable iff (reset)
    burst_valid_o |-> axi_awaddr_i[3:0] == 4'h0)
    else $error("Burst address is not 16-byte aligned");

  // AXI source must hold a stalled request steady
  a_aw_stable: assert property (@(posedge clock) disable iff (reset)
    axi_awvalid_i && !axi_awready_o |=> axi_awvalid_i
      && $stable({axi_awaddr_i, axi_awlen_i, axi_awburst_i, axi_awid_i}))
    else $error("AW request changed before its handshake");

  a_w_stable: assert property (@(posedge clock) disable iff (reset)
    axi_wvalid_i && !axi_wready_o |=> axi_wvalid_i
      && $stable({axi_wdata_i, axi_wstrb_i, axi_wlast_i}))
    else $error("W beat changed before its handshake");

endmodule

/* hw/burst_chunker.sv */
`timescale 1ns/1ps

module burst_chunker (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              burst_valid_i,
  input  logic [axi_wr_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [axi_wr_pkg::LEN_WIDTH-1:0]  len_i,
  input  logic [axi_wr_pkg::ID_WIDTH-1:0]   id_i,
  input  logic                              cmd_ready_i,
  output logic                              burst_ready_o,
  output logic                              cmd_valid_o,
  output logic [axi_wr_pkg::ADDR_WIDTH-1:0] cmd_addr_o,
  output logic [axi_wr_pkg::ID_WIDTH-1:0]   cmd_id_o,
  output logic                              cmd_seq_o
);
  import axi_wr_pkg::*;
  import sdram_cmd_pkg::*;

  logic [LEN_WIDTH:0] beats;
  logic [LEN_WIDTH:0] chunks;
  logic [LEN_WIDTH:0] remaining;

  // Up to 256 beats, so the beat count needs one extra bit
  assign beats = {1'b0, len_i} + 1'b1;
  assign chunks = beats >> $clog2(BEATS_PER_CHUNK);

  assign burst_ready_o = (remaining == '0);
  assign cmd_valid_o = !burst_ready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      remaining <= '0;
    end else if (burst_valid_i && burst_ready_o) begin
      remaining <= chunks;
    end else if (cmd_valid_o && cmd_ready_i) begin
      remaining <= remaining - 1'b1;
    end
  end

  // Current command, held while the command FIFO is full
  always_ff @(posedge clock) begin
    if (burst_valid_i && burst_ready_o) begin
      cmd_addr_o <= addr_i;
      cmd_id_o <= id_i;
      cmd_seq_o <= 1'b0;
    end else if (cmd_valid_o && cmd_ready_i) begin
      cmd_addr_o <= cmd_addr_o + CHUNK_BYTES;
      cmd_seq_o <= 1'b1;
    end
  end

  // A wrapped counter would exceed the chunk count of the longest burst
  a_no_wrap: assert property (@(posedge clock) disable iff (reset)
    cmd_valid_o |-> remaining <= (1 << LEN_WIDTH) / BEATS_PER_CHUNK)
    else $error("Chunk counter wrapped");

  // The capture FSM only offers a burst while the chunker is idle
  a_offer_idle: assert property (@(posedge clock) disable iff (reset)
    burst_valid_i |-> burst_ready_o)
    else $error("Burst offered while the chunker is busy");

endmodule

/* hw/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             in_valid_i,
  input  logic [WIDTH-1:0] in_data_i,
  input  logic             out_ready_i,
  output logic             in_ready_o,
  output logic             out_valid_o,
  output logic [WIDTH-1:0] out_data_o
);
  localparam int PTR_WIDTH = $clog2(DEPTH);

  logic [WIDTH-1:0]     mem [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH:0]   count;
  logic                 wr_en;
  logic                 rd_en;

  assign in_ready_o = (count != DEPTH);
  assign out_valid_o = (count != '0);
  assign wr_en = in_valid_i & in_ready_o;
  assign rd_en = out_valid_o & out_ready_i;
  assign out_data_o = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Fill count only moves when one side transfers alone
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

  // A write into a full FIFO would push the count past DEPTH
  a_no_write_full: assert property (@(posedge clock) disable iff (reset)
    count <= DEPTH)
    else $error("Write into a full FIFO");

  // Pointers only meet when the FIFO is empty or full
  a_no_read_empty: assert property (@(posedge clock) disable iff (reset)
    (wr_ptr == rd_ptr) == (count == '0 || count == DEPTH))
    else $error("FIFO pointers disagree with the fill count");

endmodule

/* hw/packet_fifo.sv */
`timescale 1ns/1ps

module packet_fifo (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              in_valid_i,
  input  logic                              in_last_i,
  input  logic [axi_wr_pkg::STRB_WIDTH-1:0] in_strb_i,
  input  logic [axi_wr_pkg::DATA_WIDTH-1:0] in_data_i,
  input  logic                              out_ready_i,
  output logic                              in_ready_o,
  output logic                              out_valid_o,
  output logic                              out_last_o,
  output logic [axi_wr_pkg::STRB_WIDTH-1:0] out_strb_o,
  output logic [axi_wr_pkg::DATA_WIDTH-1:0] out_data_o
);
  import axi_wr_pkg::*;
  import sdram_cmd_pkg::*;

  localparam int PTR_WIDTH = $clog2(DATA_FIFO_DEPTH);

  // Entry is last flag, strobes and data word
  logic [DATA_WIDTH+STRB_WIDTH:0] mem [DATA_FIFO_DEPTH];

  // Pointers carry one wrap bit above the address
  logic [PTR_WIDTH:0] wr_ptr;
  logic [PTR_WIDTH:0] cm_ptr;
  logic [PTR_WIDTH:0] rd_ptr;
  logic               wr_en;
  logic               rd_en;

  assign in_ready_o = (wr_ptr[PTR_WIDTH] == rd_ptr[PTR_WIDTH])
                   || (wr_ptr[PTR_WIDTH-1:0] != rd_ptr[PTR_WIDTH-1:0]);
  // Only words behind a committed last are visible
  assign out_valid_o = (rd_ptr != cm_ptr);
  assign wr_en = in_valid_i & in_ready_o;
  assign rd_en = out_valid_o & out_ready_i;
  assign {out_last_o, out_strb_o, out_data_o} = mem[rd_ptr[PTR_WIDTH-1:0]];

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      cm_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // Commit the whole packet once its last word is stored
      if (wr_en && in_last_i) begin
        cm_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr[PTR_WIDTH-1:0]] <= {in_last_i, in_strb_i, in_data_i};
    end
  end

  // Committed words can never outnumber stored words
  a_rd_behind_commit: assert property (@(posedge clock) disable iff (reset)
    (cm_ptr - rd_ptr) <= (wr_ptr - rd_ptr))
    else $error("Read pointer passed the committed pointer");

endmodule

/* hw/write_response.sv */
`timescale 1ns/1ps

module write_response (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            done_i,
  input  logic                            id_valid_i,
  input  logic [axi_wr_pkg::ID_WIDTH-1:0] id_i,
  input  logic                            axi_bready_i,
  output logic                            id_ready_o,
  output logic                            axi_bvalid_o,
  output logic [1:0]                      axi_bresp_o,
  output logic [axi_wr_pkg::ID_WIDTH-1:0] axi_bid_o
);
  import axi_wr_pkg::*;
  import sdram_cmd_pkg::*;

  logic [$clog2(ID_FIFO_DEPTH):0] pending;
  logic                           load;

  // Next response loads when one is pending or finishing now and B is free
  assign load = (pending != '0 || done_i) && (!axi_bvalid_o || axi_bready_i);
  assign id_ready_o = load;
  assign axi_bresp_o = RESP_OKAY;

  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= '0;
      axi_bvalid_o <= 1'b0;
    end else begin
      if (done_i && !load) begin
        pending <= pending + 1'b1;
      end else if (load && !done_i) begin
        pending <= pending - 1'b1;
      end
      if (load) begin
        axi_bvalid_o <= 1'b1;
      end else if (axi_bready_i) begin
        axi_bvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      axi_bid_o <= id_i;
    end
  end

  // Every finished packet has its ID queued since the AW handshake
  a_id_present: assert property (@(posedge clock) disable iff (reset)
    done_i |-> id_valid_i)
    else $error("Packet finished with no queued write ID");

endmodule

/* hw/axi_wr_path.sv */
`timescale 1ns/1ps

module axi_wr_path (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              axi_awvalid_i,
  input  logic [axi_wr_pkg::ADDR_WIDTH-1:0] axi_awaddr_i,
  input  logic [axi_wr_pkg::LEN_WIDTH-1:0]  axi_awlen_i,
  input  logic [1:0]                        axi_awburst_i,
  input  logic [axi_wr_pkg::ID_WIDTH-1:0]   axi_awid_i,
  input  logic                              axi_wvalid_i,
  input  logic [axi_wr_pkg::DATA_WIDTH-1:0] axi_wdata_i,
  input  logic [axi_wr_pkg::STRB_WIDTH-1:0] axi_wstrb_i,
  input  logic                              axi_wlast_i,
  input  logic                              axi_bready_i,
  input  logic                              mem_accept_i,
  input  logic                              mem_ready_i,
  output logic                              axi_awready_o,
  output logic                              axi_wready_o,
  output logic                              axi_bvalid_o,
  output logic [1:0]                        axi_bresp_o,
  output logic [axi_wr_pkg::ID_WIDTH-1:0]   axi_bid_o,
  output logic                              mem_store_o,
  output logic                              mem_wseq_o,
  output logic [axi_wr_pkg::ID_WIDTH-1:0]   mem_wrid_o,
  output logic [axi_wr_pkg::ADDR_WIDTH-1:0] mem_addr_o,
  output logic                              mem_valid_o,
  output logic                              mem_last_o,
  output logic [axi_wr_pkg::STRB_WIDTH-1:0] mem_strb_o,
  output logic [axi_wr_pkg::DATA_WIDTH-1:0] mem_data_o
);
  import axi_wr_pkg::*;
  import sdram_cmd_pkg::*;

  logic                  burst_valid;
  logic                  burst_ready;
  logic                  wr_valid;
  logic                  data_ready;
  logic                  cmd_valid;
  logic                  cmd_ready;
  logic                  cmd_seq;
  logic [ADDR_WIDTH-1:0] cmd_addr;
  logic [ID_WIDTH-1:0]   cmd_id;
  logic                  id_ready;
  logic                  id_valid;
  logic                  id_pop;
  logic [ID_WIDTH-1:0]   id_head;
  logic                  mem_done;

  // Handshake of the final word of a packet on the memory side
  assign mem_done = mem_valid_o & mem_ready_i & mem_last_o;

  write_capture_fsm capture_inst (
    .clock(clock), .reset(reset),
    .axi_awvalid_i(axi_awvalid_i), .axi_awaddr_i(axi_awaddr_i),
    .axi_awlen_i(axi_awlen_i), .axi_awburst_i(axi_awburst_i),
    .axi_awid_i(axi_awid_i), .axi_wvalid_i(axi_wvalid_i),
    .axi_wdata_i(axi_wdata_i), .axi_wstrb_i(axi_wstrb_i),
    .axi_wlast_i(axi_wlast_i), .burst_ready_i(burst_ready),
    .id_ready_i(id_ready), .data_ready_i(data_ready),
    .axi_awready_o(axi_awready_o), .axi_wready_o(axi_wready_o),
    .burst_valid_o(burst_valid), .wr_valid_o(wr_valid)
  );

  burst_chunker chunker_inst (
    .clock(clock), .reset(reset),
    .burst_valid_i(burst_valid), .addr_i(axi_awaddr_i),
    .len_i(axi_awlen_i), .id_i(axi_awid_i), .cmd_ready_i(cmd_ready),
    .burst_ready_o(burst_ready), .cmd_valid_o(cmd_valid),
    .cmd_addr_o(cmd_addr), .cmd_id_o(cmd_id), .cmd_seq_o(cmd_seq)
  );

  sync_fifo #(.WIDTH(CMD_WIDTH), .DEPTH(CMD_FIFO_DEPTH)) cmd_fifo_inst (
    .clock(clock), .reset(reset),
    .in_valid_i(cmd_valid), .in_data_i({cmd_addr, cmd_id, cmd_seq}),
    .out_ready_i(mem_accept_i), .in_ready_o(cmd_ready),
    .out_valid_o(mem_store_o), .out_data_o({mem_addr_o, mem_wrid_o, mem_wseq_o})
  );

  // One ID per accepted burst, popped as its response is issued
  sync_fifo #(.WIDTH(ID_WIDTH), .DEPTH(ID_FIFO_DEPTH)) id_fifo_inst (
    .clock(clock), .reset(reset),
    .in_valid_i(burst_valid), .in_data_i(axi_awid_i),
    .out_ready_i(id_pop), .in_ready_o(id_ready),
    .out_valid_o(id_valid), .out_data_o(id_head)
  );

  packet_fifo data_fifo_inst (
    .clock(clock), .reset(reset),
    .in_valid_i(wr_valid), .in_last_i(axi_wlast_i),
    .in_strb_i(axi_wstrb_i), .in_data_i(axi_wdata_i),
    .out_ready_i(mem_ready_i), .in_ready_o(data_ready),
    .out_valid_o(mem_valid_o), .out_last_o(mem_last_o),
    .out_strb_o(mem_strb_o), .out_data_o(mem_data_o)
  );

  write_response response_inst (
    .clock(clock), .reset(reset),
    .done_i(mem_done), .id_valid_i(id_valid), .id_i(id_head),
    .axi_bready_i(axi_bready_i), .id_ready_o(id_pop),
    .axi_bvalid_o(axi_bvalid_o), .axi_bresp_o(axi_bresp_o), .axi_bid_o(axi_bid_o)
  );

endmodule

/* test/axi_wr_path_tb.sv */
`timescale 1ns/1ps

module axi_wr_path_tb;
  import axi_wr_pkg::*;
  import sdram_cmd_pkg::*;

  localparam int NUM_BURSTS = 40;
  localparam int MAX_BEATS = 64;
  localparam int SEED = 11362;
  localparam int TIMEOUT_CYCLES = NUM_BURSTS * MAX_BEATS * 4 + 2000;

  logic                  clock;
  logic                  reset;
  logic                  axi_awvalid_i;
  logic [ADDR_WIDTH-1:0] axi_awaddr_i;
  logic [LEN_WIDTH-1:0]  axi_awlen_i;
  logic [1:0]            axi_awburst_i;
  logic [ID_WIDTH-1:0]   axi_awid_i;
  logic                  axi_wvalid_i;
  logic [DATA_WIDTH-1:0] axi_wdata_i;
  logic [STRB_WIDTH-1:0] axi_wstrb_i;
  logic                  axi_wlast_i;
  logic                  axi_bready_i;
  logic                  mem_accept_i;
  logic                  mem_ready_i;
  logic                  axi_awready_o;
  logic                  axi_wready_o;
  logic                  axi_bvalid_o;
  logic [1:0]            axi_bresp_o;
  logic [ID_WIDTH-1:0]   axi_bid_o;
  logic                  mem_store_o;
  logic                  mem_wseq_o;
  logic [ID_WIDTH-1:0]   mem_wrid_o;
  logic [ADDR_WIDTH-1:0] mem_addr_o;
  logic                  mem_valid_o;
  logic                  mem_last_o;
  logic [STRB_WIDTH-1:0] mem_strb_o;
  logic [DATA_WIDTH-1:0] mem_data_o;

  // Stimulus, generated before the run
  logic [ADDR_WIDTH-1:0] burst_addr [NUM_BURSTS];
  logic [LEN_WIDTH-1:0]  burst_len [NUM_BURSTS];
  logic [ID_WIDTH-1:0]   burst_id [NUM_BURSTS];
  logic [DATA_WIDTH-1:0] beat_data [NUM_BURSTS*MAX_BEATS];
  logic [STRB_WIDTH-1:0] beat_strb [NUM_BURSTS*MAX_BEATS];

  // Reference model queues
  logic [ADDR_WIDTH-1:0] exp_addr_q [$];
  logic [ID_WIDTH-1:0]   exp_cid_q [$];
  logic                  exp_seq_q [$];
  logic [DATA_WIDTH-1:0] exp_data_q [$];
  logic [STRB_WIDTH-1:0] exp_strb_q [$];
  logic                  exp_last_q [$];
  logic [ID_WIDTH-1:0]   exp_bid_q [$];
  logic [LEN_WIDTH-1:0]  fill_len_q [$];

  int          w_beat;
  int          wlast_count;
  int          mem_last_count;
  int          b_count;
  int          cycle;
  int          mismatch_errors;
  int          other_errors;
  logic        in_fill;
  int unsigned rnd;

  axi_wr_path UUT (.*);

  initial clock = 1'b0;
  always #5 clock = ~clock;

  task automatic note_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    mismatch_errors = mismatch_errors + 1;
    $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
  endtask

  task automatic note_failure(input string msg);
    other_errors = other_errors + 1;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic finish_run();
    $display("Error counts: %0d mismatches, %0d other failures",
             mismatch_errors, other_errors);
    if (mismatch_errors + other_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  task automatic make_bursts();
    for (int b = 0; b < NUM_BURSTS; b++) begin
      burst_id[b] = ID_WIDTH'($urandom_range(0, 15));
      // Lengths 3, 7, ... 63
      burst_len[b] = LEN_WIDTH'(4 * $urandom_range(1, 16) - 1);
      burst_addr[b] = $urandom & 32'hFFFF_FFF0;
      for (int i = 0; i < MAX_BEATS; i++) begin
        beat_data[b*MAX_BEATS+i] = $urandom;
        beat_strb[b*MAX_BEATS+i] = STRB_WIDTH'($urandom_range(0, 15));
      end
    end
  endtask

  task automatic drive_aw(input int b);
    repeat ($urandom_range(0, 4)) begin
      @(posedge clock);
      #1;
    end
    axi_awvalid_i = 1'b1;
    axi_awaddr_i = burst_addr[b];
    axi_awlen_i = burst_len[b];
    axi_awid_i = burst_id[b];
    @(negedge clock);
    while (!axi_awready_o) @(negedge clock);
    @(posedge clock);
    #1;
    axi_awvalid_i = 1'b0;
  endtask

  task automatic drive_w(input int b);
    for (int i = 0; i <= int'(burst_len[b]); i++) begin
      repeat ($urandom_range(0, 2)) begin
        @(posedge clock);
        #1;
      end
      axi_wvalid_i = 1'b1;
      axi_wdata_i = beat_data[b*MAX_BEATS+i];
      axi_wstrb_i = beat_strb[b*MAX_BEATS+i];
      axi_wlast_i = (i == int'(burst_len[b]));
      @(negedge clock);
      while (!axi_wready_o) @(negedge clock);
      @(posedge clock);
      #1;
      axi_wvalid_i = 1'b0;
    end
  endtask

  // Memory side and B channel take words about 70% of the time
  always begin
    @(posedge clock);
    #1;
    mem_accept_i = ($urandom % 10) < 7;
    mem_ready_i = ($urandom % 10) < 7;
    axi_bready_i = ($urandom % 10) < 7;
  end

  task automatic check_response();
    if (axi_bvalid_o) begin
      assert (b_count < mem_last_count)
        else note_failure("B response before the last memory data word of its burst");
    end
    if (axi_bvalid_o && axi_bready_i) begin
      assert (exp_bid_q.size() > 0) else note_failure("B response with no burst open");
      if (exp_bid_q.size() > 0) begin
        assert (axi_bid_o == exp_bid_q[0]) else note_mismatch("axi_bid_o", axi_bid_o, exp_bid_q[0]);
        exp_bid_q.delete(0);
      end
      assert (axi_bresp_o == RESP_OKAY) else note_mismatch("axi_bresp_o", axi_bresp_o, RESP_OKAY);
      b_count = b_count + 1;
    end
  endtask

  task automatic check_command();
    if (mem_store_o && mem_accept_i) begin
      assert (exp_addr_q.size() > 0) else note_failure("memory command with none expected");
      if (exp_addr_q.size() > 0) begin
        assert (mem_addr_o == exp_addr_q[0])
          else note_mismatch("mem_addr_o", mem_addr_o, exp_addr_q[0]);
        assert (mem_wrid_o == exp_cid_q[0])
          else note_mismatch("mem_wrid_o", mem_wrid_o, exp_cid_q[0]);
        assert (mem_wseq_o == exp_seq_q[0])
          else note_mismatch("mem_wseq_o", mem_wseq_o, exp_seq_q[0]);
        exp_addr_q.delete(0);
        exp_cid_q.delete(0);
        exp_seq_q.delete(0);
      end
    end
  endtask

  task automatic check_data();
    // A packet may only show after its wlast handshake
    if (mem_valid_o) begin
      assert (mem_last_count < wlast_count)
        else note_failure("memory data shown before the burst's wlast handshake");
    end
    if (mem_valid_o && mem_ready_i) begin
      assert (exp_data_q.size() > 0) else note_failure("memory data word with none expected");
      if (exp_data_q.size() > 0) begin
        assert (mem_data_o == exp_data_q[0])
          else note_mismatch("mem_data_o", mem_data_o, exp_data_q[0]);
        assert (mem_strb_o == exp_strb_q[0])
          else note_mismatch("mem_strb_o", mem_strb_o, exp_strb_q[0]);
        assert (mem_last_o == exp_last_q[0])
          else note_mismatch("mem_last_o", mem_last_o, exp_last_q[0]);
        exp_data_q.delete(0);
        exp_strb_q.delete(0);
        exp_last_q.delete(0);
      end
      if (mem_last_o) begin
        mem_last_count = mem_last_count + 1;
      end
    end
  endtask

  task automatic track_axi();
    int chunks;
    if (in_fill) begin
      assert (!axi_awready_o) else note_failure("awready high while a burst is filling");
    end
    if (axi_wvalid_i && axi_wready_o) begin
      assert (fill_len_q.size() > 0) else note_failure("W beat accepted with no open burst");
      if (fill_len_q.size() > 0) begin
        exp_data_q.push_back(axi_wdata_i);
        exp_strb_q.push_back(axi_wstrb_i);
        // Last beat follows from the burst length
        exp_last_q.push_back(w_beat == int'(fill_len_q[0]));
        if (w_beat == int'(fill_len_q[0])) begin
          w_beat = 0;
          fill_len_q.delete(0);
          wlast_count = wlast_count + 1;
          in_fill = 1'b0;
        end else begin
          w_beat = w_beat + 1;
        end
      end
    end
    if (axi_awvalid_i && axi_awready_o) begin
      chunks = (int'(axi_awlen_i) + 1) / BEATS_PER_CHUNK;
      for (int k = 0; k < chunks; k++) begin
        exp_addr_q.push_back(axi_awaddr_i + ADDR_WIDTH'(CHUNK_BYTES * k));
        exp_cid_q.push_back(axi_awid_i);
        exp_seq_q.push_back(k != 0);
      end
      exp_bid_q.push_back(axi_awid_i);
      fill_len_q.push_back(axi_awlen_i);
      in_fill = 1'b1;
    end
  endtask

  // Outputs are sampled at the falling edge, where they are settled
  always @(negedge clock) begin
    if (reset) begin
      if (cycle > 0) begin
        assert (!axi_awready_o && !axi_wready_o && !axi_bvalid_o && !mem_store_o
                && !mem_valid_o)
          else note_failure("valid or ready output high during reset");
      end
    end else begin
      check_response();
      check_command();
      check_data();
      track_axi();
    end
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      other_errors = other_errors + 1;
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      finish_run();
    end
  end

  initial begin
    rnd = $urandom(SEED);
    in_fill = 1'b0;
    make_bursts();
    reset = 1'b1;
    axi_awvalid_i = 1'b0;
    axi_awaddr_i = '0;
    axi_awlen_i = '0;
    axi_awburst_i = BURST_INCR;
    axi_awid_i = '0;
    axi_wvalid_i = 1'b0;
    axi_wdata_i = '0;
    axi_wstrb_i = '0;
    axi_wlast_i = 1'b0;
    axi_bready_i = 1'b0;
    mem_accept_i = 1'b0;
    mem_ready_i = 1'b0;
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;
    fork
      begin
        for (int b = 0; b < NUM_BURSTS; b++) drive_aw(b);
      end
      begin
        for (int b = 0; b < NUM_BURSTS; b++) drive_w(b);
      end
    join
    while (b_count < NUM_BURSTS) @(negedge clock);
    // Extra cycles to catch stray words or responses
    repeat (20) @(negedge clock);
    assert (b_count == NUM_BURSTS) else note_mismatch("b_count", b_count, NUM_BURSTS);
    assert (exp_addr_q.size() == 0) else note_failure("expected memory commands never came");
    assert (exp_data_q.size() == 0) else note_failure("expected memory data never came");
    assert (exp_bid_q.size() == 0) else note_failure("expected B responses never came");
    finish_run();
  end

endmodule

/* list.f */
hw/axi_wr_pkg.sv
hw/sdram_cmd_pkg.sv
hw/write_capture_fsm.sv
hw/burst_chunker.sv
hw/sync_fifo.sv
hw/packet_fifo.sv
hw/write_response.sv
hw/axi_wr_path.sv
test/axi_wr_path_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= axi_wr_path_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Pass or fail is decided by the pass message in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
